//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_snes_cart_loader
FILELIST  ?= snes_cart_loader.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) test/tb_model.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/cart_pkg.sv
/*
  Shared types and constants for the cartridge load controller.
  Header addresses are raw host byte addresses and include the copier header.
  Fill rules read address bits up to 9, and a narrower RAM sees zeros there.
  header_mode value 3 is unused and behaves as automatic.
*/
`default_nettype none

package cart_pkg;

	typedef logic [7:0]  dl_index_t;
	typedef logic [23:0] rom_addr_t;
	typedef logic [15:0] word_t;

	// One ROM write, address on top
	typedef struct packed {
		rom_addr_t addr;
		word_t     data;
	} rom_write_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef enum logic [1:0] {
		FILL_9966 = 2'd0,
		FILL_00FF = 2'd1,
		FILL_55   = 2'd2,
		FILL_FF   = 2'd3
	} fill_pattern_t;

	typedef enum logic [1:0] {
		HDR_AUTO  = 2'd0,
		HDR_LOROM = 2'd1,
		HDR_HIROM = 2'd2
	} header_mode_t;

	localparam int          COPIER_OFFSET    = 512;
	localparam logic [3:0]  DEFAULT_ROM_SIZE = 4'd12;

	// ROM size byte sits in the high half of this word, RAM size two bytes on
	localparam logic [24:0] LOROM_HDR_ADDR = 25'h007FD6 + 25'(COPIER_OFFSET);
	localparam logic [24:0] HIROM_HDR_ADDR = 25'h00FFD6 + 25'(COPIER_OFFSET);

	// Index 0 or low bits 01 is a cartridge image
	function automatic logic is_cart_index(input dl_index_t index);
		return (index == 8'h00) || (index[5:0] == 6'h01);
	endfunction

	function automatic logic is_cheat_index(input dl_index_t index);
		return &index;
	endfunction

	// 1 KB shifted by size, minus one; RAM size 0 means no RAM
	function automatic rom_addr_t mask_from_size(input logic [3:0] size, input logic is_ram);
		rom_addr_t mask;
		mask = (24'd1024 << size) - 24'd1;
		if (is_ram && size == 4'd0) begin
			mask = '0;
		end
		return mask;
	endfunction

endpackage

`default_nettype wire

//--- loader/cheat_assembler.sv
/*
  Builds one cheat record from eight words at offsets 0 to 14.
  A record is only emitted when every earlier word of the group arrived.
  A finished record is held until rec_ready; the router stalls cheat words
  meanwhile, so the fields can be written in place.
*/
`timescale 1ns/1ns
`default_nettype none

module cheat_assembler import cart_pkg::*; (
	input  wire         clk_sys,
	input  wire         RESET,
	input  wire         word_valid,
	input  wire [3:0]   word_offset,
	input  wire word_t  word,
	input  wire         cart_start,
	output logic        rec_valid,
	output cheat_code_t rec,
	input  wire         rec_ready
);

	logic [6:0] seen;
	logic [2:0] slot;
	logic       complete;

	assign slot     = word_offset[3:1];
	assign complete = word_valid && (slot == 3'd7) && (&seen);

	// Lower half of each field comes first
	always_ff @(posedge clk_sys) begin
		if (word_valid) begin
			case (slot)
				3'd0: rec.flags[15:0]    <= word;
				3'd1: rec.flags[31:16]   <= word;
				3'd2: rec.addr[15:0]     <= word;
				3'd3: rec.addr[31:16]    <= word;
				3'd4: rec.compare[15:0]  <= word;
				3'd5: rec.compare[31:16] <= word;
				3'd6: rec.replace[15:0]  <= word;
				default: rec.replace[31:16] <= word;
			endcase
		end
	end

	// Words collected so far in the current group
	always_ff @(posedge clk_sys) begin
		if (RESET || cart_start) begin
			seen <= '0;
		end else if (word_valid) begin
			if (slot == 3'd0) begin
				seen <= 7'd1;
			end else if (slot == 3'd7) begin
				seen <= '0;
			end else begin
				seen[slot] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rec_valid <= 1'b0;
		end else if (complete) begin
			rec_valid <= 1'b1;
		end else if (rec_ready) begin
			rec_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- loader/download_router.sv
/*
  Steers host download words to the ROM, cheat and header paths.
  Words with an unknown index are accepted and dropped.
  dl_ready stays low on the first cycle of a cartridge download so that
  the RAM clear gets in ahead of any data.
*/
`timescale 1ns/1ns
`default_nettype none

module download_router import cart_pkg::*; (
	input  wire            clk_sys,
	input  wire            RESET,
	input  wire            dl_active,
	input  wire dl_index_t dl_index,
	input  wire            dl_valid,
	output logic           dl_ready,
	input  wire [24:0]     dl_addr,
	input  wire word_t     dl_data,
	input  wire            clearing,
	input  wire            rom_in_ready,
	output logic           rom_in_valid,
	output rom_write_t     rom_in,
	input  wire            code_in_ready,
	output logic           word_valid,
	output logic [3:0]     word_offset,
	output word_t          word,
	output logic           hdr_strobe,
	output logic [24:0]    hdr_addr,
	output logic           cart_start
);

	logic        cart_sel;
	logic        code_sel;
	logic        cart_seen;
	logic        sel_ready;
	logic        accept;
	logic [24:0] cart_addr;

	assign cart_sel = is_cart_index(dl_index);
	assign code_sel = is_cheat_index(dl_index);

	// Previous cycle was already inside a cartridge download
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_seen <= 1'b0;
		end else begin
			cart_seen <= dl_active && cart_sel;
		end
	end

	assign cart_start = dl_active && cart_sel && !cart_seen;

	always_comb begin
		if (cart_sel) begin
			sel_ready = rom_in_ready;
		end else if (code_sel) begin
			sel_ready = code_in_ready;
		end else begin
			sel_ready = 1'b1;
		end
	end

	assign dl_ready = dl_active && !clearing && !cart_start && sel_ready;
	assign accept   = dl_valid && dl_ready;

	// ============================================================
	// Destinations

	assign cart_addr    = dl_addr - 25'(COPIER_OFFSET);
	assign rom_in_valid = accept && cart_sel;
	assign rom_in       = '{addr: cart_addr[23:0], data: dl_data};

	assign word_valid  = accept && code_sel;
	assign word_offset = dl_addr[3:0];
	assign word        = dl_data;

	// Header capture sees the raw host address
	assign hdr_strobe = accept && cart_sel;
	assign hdr_addr   = dl_addr;

	// Host offers words only inside a download window
	a_valid_in_download: assert property (@(posedge clk_sys) disable iff (RESET)
		dl_valid |-> dl_active);

endmodule

`default_nettype wire

//--- loader/header_parser.sv
/*
  Picks ROM type, size fields and region out of the cartridge download.
  Auto mode reads the size and type bytes from word 0 of the copier header;
  forced modes read the internal header at 7FD6 or FFD6 past the offset.
  region_sel 2 forces NTSC, 3 forces PAL, 0 and 1 follow the header.
  pal only moves while no cartridge download is running.
*/
`timescale 1ns/1ns
`default_nettype none

module header_parser import cart_pkg::*; (
	input  wire               clk_sys,
	input  wire               RESET,
	input  wire               hdr_strobe,
	input  wire [24:0]        hdr_addr,
	input  wire word_t        word,
	input  wire               cart_active,
	input  wire               cart_start,
	input  wire header_mode_t header_mode,
	input  wire [1:0]         region_sel,
	output logic [7:0]        rom_type,
	output rom_addr_t         rom_mask,
	output rom_addr_t         ram_mask,
	output logic              pal
);

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        hdr_region;
	logic        forced;
	logic [24:0] hdr_base;

	assign forced   = (header_mode == HDR_LOROM) || (header_mode == HDR_HIROM);
	assign hdr_base = (header_mode == HDR_HIROM) ? HIROM_HDR_ADDR : LOROM_HDR_ADDR;

	// ============================================================
	// Field capture

	always_ff @(posedge clk_sys) begin
		if (RESET || cart_start) begin
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			hdr_region <= 1'b0;
			rom_type   <= 8'h00;
		end else if (hdr_strobe) begin
			if (hdr_addr == 25'd0) begin
				case (header_mode)
					HDR_LOROM: rom_type <= 8'h00;
					HDR_HIROM: rom_type <= 8'h01;
					default: begin
						rom_type <= word[15:8];
						// Zero size byte keeps the defaults
						if (word[7:0] != 8'h00) begin
							{ram_size, rom_size} <= word[7:0];
						end
					end
				endcase
			end
			if (hdr_addr == 25'd2) begin
				hdr_region <= word[8];
			end
			if (forced && hdr_addr == hdr_base) begin
				rom_size <= word[11:8];
			end
			if (forced && hdr_addr == hdr_base + 25'd2) begin
				ram_size <= word[3:0];
			end
		end
	end

	assign rom_mask = mask_from_size(rom_size, 1'b0);
	assign ram_mask = mask_from_size(ram_size, 1'b1);

	// Video region, frozen during a download
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pal <= 1'b0;
		end else if (!cart_active) begin
			pal <= region_sel[1] ? region_sel[0] : hdr_region;
		end
	end

endmodule

`default_nettype wire

//--- loader/write_skid.sv
/*
  Two-entry valid/ready register stage, registered in both directions.
  An accepted item shows up on the output one cycle later.
  in_ready drops only while a second item waits in the spill register.
*/
`timescale 1ns/1ns
`default_nettype none

module write_skid #(
	parameter type payload_t = logic [7:0]
) (
	input  wire           clk_sys,
	input  wire           RESET,
	input  wire           in_valid,
	output logic          in_ready,
	input  wire payload_t in_data,
	output logic          out_valid,
	input  wire           out_ready,
	output payload_t      out_data
);

	payload_t spill_data;
	logic     spill_valid;
	logic     drain;
	logic     load_spill;

	assign in_ready = !spill_valid;

	// Output register is free this cycle
	assign drain      = out_ready || !out_valid;
	assign load_spill = !drain && in_valid && !spill_valid;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			out_valid   <= 1'b0;
			spill_valid <= 1'b0;
		end else if (drain) begin
			out_valid   <= spill_valid || in_valid;
			spill_valid <= 1'b0;
		end else if (load_spill) begin
			spill_valid <= 1'b1;
		end
	end

	// Spilled item goes out before anything new
	always_ff @(posedge clk_sys) begin
		if (drain) begin
			out_data <= spill_valid ? spill_data : in_data;
		end
		if (load_spill) begin
			spill_data <= in_data;
		end
	end

	// Upstream keeps an offered item until it is taken
	a_hold_input: assert property (@(posedge clk_sys) disable iff (RESET)
		in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

`default_nettype wire

//--- snes_cart_loader.f
+incdir+test
common/cart_pkg.sv
loader/download_router.sv
loader/header_parser.sv
loader/cheat_assembler.sv
loader/write_skid.sv
source/ram_clear.sv
source/snes_cart_loader.sv
test/tb_snes_cart_loader.sv

//--- source/ram_clear.sv
/*
  Work RAM clear at the start of each cartridge download.
  One byte is written every second cycle, addresses 0 up to all ones, so
  clearing lasts 2 * 2^FILL_ADDR_BITS cycles.
  The fill pattern is latched when the clear starts.
*/
`timescale 1ns/1ns
`default_nettype none

module ram_clear import cart_pkg::*; #(
	parameter int FILL_ADDR_BITS = 17
) (
	input  wire                       clk_sys,
	input  wire                       RESET,
	input  wire                       cart_start,
	input  wire fill_pattern_t        fill_pattern,
	output logic                      clearing,
	output logic                      fill_valid,
	output logic [FILL_ADDR_BITS-1:0] fill_addr,
	output logic [7:0]                fill_data
);

	// Pattern rules look at bits up to 9
	localparam int PAT_BITS = (FILL_ADDR_BITS > 10) ? FILL_ADDR_BITS : 10;

	logic                phase;
	fill_pattern_t       pattern;
	logic [PAT_BITS-1:0] pat_addr;

	// ============================================================
	// Address sweep

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			phase     <= 1'b0;
			fill_addr <= '0;
			pattern   <= FILL_9966;
		end else if (cart_start) begin
			clearing  <= 1'b1;
			phase     <= 1'b0;
			fill_addr <= '0;
			pattern   <= fill_pattern;
		end else if (clearing) begin
			phase <= !phase;
			if (phase) begin
				if (&fill_addr) begin
					clearing <= 1'b0;
				end else begin
					fill_addr <= fill_addr + 1'b1;
				end
			end
		end
	end

	// Write on the first half of each address slot
	assign fill_valid = clearing && !phase;

	// ============================================================
	// Pattern decode

	assign pat_addr = PAT_BITS'(fill_addr);

	always_comb begin
		fill_data = 8'hFF;
		case (pattern)
			FILL_9966: fill_data = (pat_addr[8] ^ pat_addr[2]) ? 8'h66 : 8'h99;
			FILL_00FF: fill_data = (pat_addr[9] ^ pat_addr[0]) ? 8'hFF : 8'h00;
			FILL_55:   fill_data = 8'h55;
			default:   fill_data = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

//--- source/snes_cart_loader.sv
/*
  Cartridge load controller top level.
  Host downloads stall while work RAM is being cleared.
  ROM words leave one cycle after acceptance, cheat records two cycles
  after their last word.
*/
`timescale 1ns/1ns
`default_nettype none

module snes_cart_loader import cart_pkg::*; #(
	parameter int FILL_ADDR_BITS = 17
) (
	input  wire                       clk_sys,
	input  wire                       RESET,
	input  wire                       dl_active,
	input  wire dl_index_t            dl_index,
	input  wire                       dl_valid,
	output logic                      dl_ready,
	input  wire [24:0]                dl_addr,
	input  wire word_t                dl_data,
	input  wire header_mode_t         header_mode,
	input  wire [1:0]                 region_sel,
	input  wire fill_pattern_t        fill_pattern,
	output logic                      rom_valid,
	input  wire                       rom_ready,
	output rom_addr_t                 rom_addr,
	output word_t                     rom_data,
	output logic                      code_valid,
	input  wire                       code_ready,
	output cheat_code_t               code,
	output logic                      fill_valid,
	output logic [FILL_ADDR_BITS-1:0] fill_addr,
	output logic [7:0]                fill_data,
	output logic                      clearing,
	output logic [7:0]                rom_type,
	output rom_addr_t                 rom_mask,
	output rom_addr_t                 ram_mask,
	output logic                      pal
);

	wire         cart_active = dl_active && is_cart_index(dl_index);
	wire         cart_start;
	wire         rom_in_valid;
	wire         rom_in_ready;
	rom_write_t  rom_in;
	rom_write_t  rom_out;
	wire         code_in_ready;
	wire         word_valid;
	wire [3:0]   word_offset;
	word_t       word;
	wire         hdr_strobe;
	wire [24:0]  hdr_addr;
	wire         rec_valid;
	cheat_code_t rec;

	download_router u_router (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.dl_active     (dl_active),
		.dl_index      (dl_index),
		.dl_valid      (dl_valid),
		.dl_ready      (dl_ready),
		.dl_addr       (dl_addr),
		.dl_data       (dl_data),
		.clearing      (clearing),
		.rom_in_ready  (rom_in_ready),
		.rom_in_valid  (rom_in_valid),
		.rom_in        (rom_in),
		.code_in_ready (code_in_ready),
		.word_valid    (word_valid),
		.word_offset   (word_offset),
		.word          (word),
		.hdr_strobe    (hdr_strobe),
		.hdr_addr      (hdr_addr),
		.cart_start    (cart_start)
	);

	header_parser u_header (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.hdr_strobe  (hdr_strobe),
		.hdr_addr    (hdr_addr),
		.word        (rom_in.data),
		.cart_active (cart_active),
		.cart_start  (cart_start),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	cheat_assembler u_cheat (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.word_valid  (word_valid),
		.word_offset (word_offset),
		.word        (word),
		.cart_start  (cart_start),
		.rec_valid   (rec_valid),
		.rec         (rec),
		.rec_ready   (code_in_ready)
	);

	// ============================================================
	// Output stages

	write_skid #(.payload_t(rom_write_t)) u_rom_skid (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.in_valid  (rom_in_valid),
		.in_ready  (rom_in_ready),
		.in_data   (rom_in),
		.out_valid (rom_valid),
		.out_ready (rom_ready),
		.out_data  (rom_out)
	);

	assign rom_addr = rom_out.addr;
	assign rom_data = rom_out.data;

	write_skid #(.payload_t(cheat_code_t)) u_code_skid (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.in_valid  (rec_valid),
		.in_ready  (code_in_ready),
		.in_data   (rec),
		.out_valid (code_valid),
		.out_ready (code_ready),
		.out_data  (code)
	);

	ram_clear #(.FILL_ADDR_BITS(FILL_ADDR_BITS)) u_clear (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_start   (cart_start),
		.fill_pattern (fill_pattern),
		.clearing     (clearing),
		.fill_valid   (fill_valid),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data)
	);

endmodule

`default_nettype wire

//--- test/tb_model.svh
/*
  Reference model for the cartridge loader testbench.
  Holds the expected ROM writes and cheat records in order.
  Fill rules assume a 10-bit view of the fill address.
*/
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

rom_write_t  rom_exp_q[$];
cheat_code_t code_exp_q[$];
word_t       cheat_words[8];
logic [7:0]  cheat_have;

// Byte that the clear writes at one address
function automatic logic [7:0] expect_fill(input fill_pattern_t pat, input logic [9:0] a);
	logic [7:0] b;
	case (pat)
		FILL_9966: b = (a[8] ^ a[2]) ? 8'h66 : 8'h99;
		FILL_00FF: b = (a[9] ^ a[0]) ? 8'hFF : 8'h00;
		FILL_55:   b = 8'h55;
		default:   b = 8'hFF;
	endcase
	return b;
endfunction

// 1 KB times two to the size, as a byte mask
function automatic rom_addr_t expect_mask(input logic [3:0] size, input logic is_ram);
	logic [31:0] full;
	full = (32'd1024 << size) - 32'd1;
	if (is_ram && size == 4'd0) begin
		full = 32'd0;
	end
	return full[23:0];
endfunction

function automatic rom_write_t expect_rom(input logic [24:0] addr, input word_t data);
	logic [24:0] off;
	off = addr - 25'd512;
	return '{addr: off[23:0], data: data};
endfunction

// New cartridge download drops any partial cheat group
task automatic model_cart_start();
	cheat_have = '0;
endtask

task automatic model_cheat_word(input logic [3:0] offset, input word_t data);
	logic [2:0]  slot;
	cheat_code_t r;
	slot = offset[3:1];
	if (slot == 3'd0) begin
		cheat_have = '0;
	end
	cheat_words[slot] = data;
	cheat_have[slot]  = 1'b1;
	if (slot == 3'd7) begin
		if (&cheat_have) begin
			r.flags   = {cheat_words[1], cheat_words[0]};
			r.addr    = {cheat_words[3], cheat_words[2]};
			r.compare = {cheat_words[5], cheat_words[4]};
			r.replace = {cheat_words[7], cheat_words[6]};
			code_exp_q.push_back(r);
		end
		cheat_have = '0;
	end
endtask

`endif

//--- test/tb_snes_cart_loader.sv
/*
  Testbench for the cartridge load controller, FILL_ADDR_BITS set to 8.
  Inputs change on the falling edge; output ready levels and word gaps
  come from a 17-bit LFSR with a fixed seed.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_snes_cart_loader import cart_pkg::*; ();

	localparam int FILL_BITS    = 8;
	localparam int CLEAR_CYCLES = 2 * (1 << FILL_BITS);

	logic          clk_sys = 1'b0;
	logic          RESET;
	logic          dl_active;
	dl_index_t     dl_index;
	logic          dl_valid;
	logic          dl_ready;
	logic [24:0]   dl_addr;
	word_t         dl_data;
	header_mode_t  header_mode;
	logic [1:0]    region_sel;
	fill_pattern_t fill_pattern;
	logic          rom_valid;
	logic          rom_ready = 1'b0;
	rom_addr_t     rom_addr;
	word_t         rom_data;
	logic          code_valid;
	logic          code_ready = 1'b0;
	cheat_code_t   code;
	logic          fill_valid;
	logic [FILL_BITS-1:0] fill_addr;
	logic [7:0]    fill_data;
	logic          clearing;
	logic [7:0]    rom_type;
	rom_addr_t     rom_mask;
	rom_addr_t     ram_mask;
	logic          pal;

	logic [16:0]   lfsr = 17'd72984;
	logic          monitors_on = 1'b0;
	dl_index_t     cur_index;
	int            errors = 0;
	int            test_base;
	int            tests_run = 0;
	int            tests_failed = 0;
	int            codes_seen = 0;

	`include "tb_model.svh"

	snes_cart_loader #(.FILL_ADDR_BITS(FILL_BITS)) snes_cart_loader_i (
		.clk_sys(clk_sys), .RESET(RESET), .dl_active(dl_active), .dl_index(dl_index),
		.dl_valid(dl_valid), .dl_ready(dl_ready), .dl_addr(dl_addr), .dl_data(dl_data),
		.header_mode(header_mode), .region_sel(region_sel), .fill_pattern(fill_pattern),
		.rom_valid(rom_valid), .rom_ready(rom_ready), .rom_addr(rom_addr),
		.rom_data(rom_data), .code_valid(code_valid), .code_ready(code_ready),
		.code(code), .fill_valid(fill_valid), .fill_addr(fill_addr),
		.fill_data(fill_data), .clearing(clearing), .rom_type(rom_type),
		.rom_mask(rom_mask), .ram_mask(ram_mask), .pal(pal)
	);

	always #50 clk_sys = ~clk_sys;

	// Fibonacci LFSR with taps 17 and 14 stepped once per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[16] ^ lfsr[13];
			lfsr = {lfsr[15:0], fb};
			v    = {v[14:0], fb};
		end
		return v;
	endfunction

	// ============================================================
	// Checks

	task automatic compare_rom(input rom_write_t got, input rom_write_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t rom_addr/rom_data got %h/%h expected %h/%h",
				$time, got.addr, got.data, exp.addr, exp.data);
		end
	endtask

	task automatic compare_code(input cheat_code_t got, input cheat_code_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t code got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic compare_fill(input logic [FILL_BITS-1:0] got_addr,
		input logic [FILL_BITS-1:0] exp_addr, input logic [7:0] got_data,
		input logic [7:0] exp_data);
		if (got_addr !== exp_addr) begin
			errors++;
			$display("[ERROR] %0t fill_addr got %h expected %h", $time, got_addr, exp_addr);
		end
		if (got_data !== exp_data) begin
			errors++;
			$display("[ERROR] %0t fill_data got %h expected %h", $time, got_data, exp_data);
		end
	endtask

	task automatic compare_header(input string name, input rom_addr_t got, input rom_addr_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("Check failed at %0t: %s", $time, msg);
	endtask

	task automatic timeout_abort(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	// Output sinks pick a ready level and check what moves on the next rising edge
	always @(negedge clk_sys) begin
		if (monitors_on) begin
			rom_ready = (rand_bits(2) != 16'd0);
			if (rom_valid && rom_ready) begin
				if (rom_exp_q.size() == 0) begin
					report_problem("ROM write offered with none expected");
				end else begin
					compare_rom(rom_write_t'{addr: rom_addr, data: rom_data},
						rom_exp_q.pop_front());
				end
			end
			code_ready = (rand_bits(1) != 16'd0);
			if (code_valid && code_ready) begin
				codes_seen++;
				if (code_exp_q.size() == 0) begin
					report_problem("cheat record offered with none expected");
				end else begin
					compare_code(code, code_exp_q.pop_front());
				end
			end
		end
	end

	// ============================================================
	// Stimulus

	task automatic start_cart(input fill_pattern_t pat);
		int clr;
		int fills;
		int guard;
		logic seen_rise;
		logic [FILL_BITS-1:0] exp_addr;
		clr = 0;
		fills = 0;
		guard = 0;
		seen_rise = 1'b0;
		exp_addr = '0;
		@(negedge clk_sys);
		fill_pattern = pat;
		dl_index = 8'h00;
		cur_index = 8'h00;
		dl_active = 1'b1;
		model_cart_start();
		while (!(seen_rise && !clearing)) begin
			@(negedge clk_sys);
			guard++;
			if (guard > 4 * CLEAR_CYCLES) begin
				timeout_abort("the RAM clear to finish");
			end
			if (clearing) begin
				seen_rise = 1'b1;
				clr++;
				if (dl_ready) begin
					report_problem("dl_ready high while clearing");
				end
				if (fill_valid) begin
					compare_fill(fill_addr, exp_addr, fill_data, expect_fill(pat, 10'(exp_addr)));
					exp_addr++;
					fills++;
				end
			end
		end
		if (clr != CLEAR_CYCLES) begin
			report_problem($sformatf("clearing lasted %0d cycles instead of %0d", clr, CLEAR_CYCLES));
		end
		if (fills != (1 << FILL_BITS)) begin
			report_problem($sformatf("%0d fill writes instead of %0d", fills, 1 << FILL_BITS));
		end
	endtask

	task automatic start_cheat();
		@(negedge clk_sys);
		dl_index = 8'hFF;
		cur_index = 8'hFF;
		dl_active = 1'b1;
	endtask

	task automatic send_word(input logic [24:0] addr, input word_t data);
		logic [15:0] gap;
		int guard;
		logic accepted;
		gap = rand_bits(2);
		guard = 0;
		accepted = 1'b0;
		repeat (int'(gap)) begin
			@(negedge clk_sys);
			dl_valid = 1'b0;
		end
		@(negedge clk_sys);
		dl_valid = 1'b1;
		dl_addr = addr;
		dl_data = data;
		while (!accepted) begin
			#10;
			if (dl_ready) begin
				accepted = 1'b1;
			end else begin
				guard++;
				if (guard > 200) begin
					timeout_abort("dl_ready");
				end
				@(negedge clk_sys);
			end
		end
		if (cur_index == 8'hFF) begin
			model_cheat_word(addr[3:0], data);
		end else begin
			rom_exp_q.push_back(expect_rom(addr, data));
		end
	endtask

	task automatic end_download();
		@(negedge clk_sys);
		dl_valid = 1'b0;
		dl_active = 1'b0;
	endtask

	task automatic wait_drain();
		int guard;
		guard = 0;
		while (rom_exp_q.size() != 0 || code_exp_q.size() != 0) begin
			@(negedge clk_sys);
			guard++;
			if (guard > 2000) begin
				timeout_abort("the output queues to drain");
			end
		end
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic send_random_words(input int count);
		logic [15:0] r;
		for (int i = 0; i < count; i++) begin
			r = rand_bits(14);
			send_word(25'h400 + {10'd0, r[13:0], 1'b0}, rand_bits(16));
		end
	endtask

	task automatic check_header(input logic [7:0] typ, input logic [3:0] rsize,
		input logic [3:0] asize, input logic exp_pal);
		repeat (2) @(negedge clk_sys);
		compare_header("rom_type", {16'd0, rom_type}, {16'd0, typ});
		compare_header("rom_mask", rom_mask, expect_mask(rsize, 1'b0));
		compare_header("ram_mask", ram_mask, expect_mask(asize, 1'b1));
		compare_header("pal", {23'd0, pal}, {23'd0, exp_pal});
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors > test_base) begin
			tests_failed++;
			$display("Test %0d %s: FAIL (%0d errors)", tests_run, name, errors - test_base);
		end else begin
			$display("Test %0d %s: ok", tests_run, name);
		end
		test_base = errors;
	endtask

	initial begin
		RESET = 1'b1;
		dl_active = 1'b0;
		dl_index = 8'h00;
		dl_valid = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		header_mode = HDR_AUTO;
		region_sel = 2'd0;
		fill_pattern = FILL_9966;
		cur_index = 8'h00;
		test_base = 0;
		model_cart_start();
		repeat (3) @(negedge clk_sys);
		RESET = 1'b0;
		monitors_on = 1'b1;

		if ({dl_ready, rom_valid, code_valid, fill_valid, clearing} !== 5'b00000) begin
			report_problem("handshake or clear output not low after reset");
		end
		finish_test("reset state");

		start_cart(FILL_9966);
		end_download();
		start_cart(FILL_00FF);
		end_download();
		start_cart(FILL_55);
		end_download();
		start_cart(FILL_FF);
		end_download();
		finish_test("RAM clear patterns");

		start_cart(FILL_55);
		send_random_words(40);
		end_download();
		wait_drain();
		finish_test("ROM write path");

		// Auto mode follows the header region bit
		header_mode = HDR_AUTO;
		region_sel = 2'd0;
		start_cart(FILL_FF);
		send_word(25'd0, 16'h353A);
		send_word(25'd2, 16'h0100);
		send_random_words(4);
		end_download();
		check_header(8'h35, 4'hA, 4'h3, 1'b1);
		header_mode = HDR_LOROM;
		region_sel = 2'd3;
		start_cart(FILL_9966);
		send_word(25'd0, 16'h1234);
		send_word(25'd2, 16'h0000);
		send_word(25'h0081D6, 16'h0920);
		send_word(25'h0081D8, 16'h00F0);
		end_download();
		check_header(8'h00, 4'h9, 4'h0, 1'b1);
		header_mode = HDR_HIROM;
		region_sel = 2'd2;
		start_cart(FILL_00FF);
		send_word(25'd0, 16'h5555);
		send_word(25'd2, 16'h0100);
		send_word(25'h0101D6, 16'h0B00);
		send_word(25'h0101D8, 16'h0005);
		end_download();
		check_header(8'h01, 4'hB, 4'h5, 1'b0);
		wait_drain();
		finish_test("header modes");

		codes_seen = 0;
		start_cheat();
		for (int g = 0; g < 4; g++) begin
			for (int k = 0; k < 8; k++) begin
				send_word(25'(g * 16 + k * 2), rand_bits(16));
			end
		end
		// Partial group cut off by a cartridge download and then resumed
		for (int k = 0; k < 3; k++) begin
			send_word(25'(64 + k * 2), rand_bits(16));
		end
		end_download();
		start_cart(FILL_55);
		send_word(25'h600, 16'hBEEF);
		end_download();
		start_cheat();
		for (int k = 3; k < 8; k++) begin
			send_word(25'(64 + k * 2), rand_bits(16));
		end
		for (int k = 0; k < 8; k++) begin
			send_word(25'(80 + k * 2), rand_bits(16));
		end
		end_download();
		wait_drain();
		if (codes_seen != 5) begin
			report_problem($sformatf("%0d cheat records seen instead of 5", codes_seen));
		end
		finish_test("cheat records");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
